// File: source/alu_op_pkg.sv
`default_nettype none

package alu_op_pkg;

  // Operator codes of the ALU
  typedef enum logic [6:0] {
    ALU_ADD  = 7'b0011000,
    ALU_SUB  = 7'b0011001,
    ALU_XOR  = 7'b0101111,
    ALU_OR   = 7'b0101110,
    ALU_AND  = 7'b0010101,
    ALU_SRA  = 7'b0100100,
    ALU_SRL  = 7'b0100101,
    ALU_SLL  = 7'b0100111,
    ALU_LTS  = 7'b0000000,
    ALU_LTU  = 7'b0000001,
    ALU_SLTS = 7'b0000010,
    ALU_SLTU = 7'b0000011,
    ALU_LES  = 7'b0000100,
    ALU_LEU  = 7'b0000101,
    ALU_GTS  = 7'b0001000,
    ALU_GTU  = 7'b0001001,
    ALU_GES  = 7'b0001010,
    ALU_GEU  = 7'b0001011,
    ALU_EQ   = 7'b0001100,
    ALU_NE   = 7'b0001101,
    ALU_MIN  = 7'b0010000,
    ALU_MINU = 7'b0010001,
    ALU_MAX  = 7'b0010010,
    ALU_MAXU = 7'b0010011,
    ALU_DIVU = 7'b0110000,
    ALU_DIV  = 7'b0110001,
    ALU_REMU = 7'b0110010,
    ALU_REM  = 7'b0110011
  } alu_opcode_e;

  // Lane split of the data word
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

endpackage

`default_nettype wire

// File: source/simd_pkg.sv
`default_nettype none

package simd_pkg;

  parameter int unsigned WORD_W = 32;
  parameter int unsigned HALF_W = 16;
  parameter int unsigned BYTE_W = 8;

  parameter int unsigned HALF_LANES = WORD_W / HALF_W;
  parameter int unsigned BYTE_LANES = WORD_W / BYTE_W;

  // One operand word seen as a word, as halves or as bytes
  typedef union packed {
    logic [WORD_W-1:0]                 word;
    logic [HALF_LANES-1:0][HALF_W-1:0] halves;
    logic [BYTE_LANES-1:0][BYTE_W-1:0] bytes;
  } simd_word_u;

endpackage

`default_nettype wire

// File: source/simd_adder.sv
`timescale 1ns/10ps
`default_nettype none

module simd_adder (
  input  simd_pkg::simd_word_u  operand_a_i,
  input  simd_pkg::simd_word_u  operand_b_i,
  input  logic                  sub_i,
  input  alu_op_pkg::vec_mode_e vector_mode_i,
  output logic [31:0]           sum_o
);

  simd_pkg::simd_word_u op_b;
  logic [3:0]           lane_cut;
  logic [35:0]          in_a;
  logic [35:0]          in_b;
  logic [35:0]          sum_ext;

  assign op_b.word = sub_i ? ~operand_b_i.word : operand_b_i.word;

  // Byte positions where a new lane starts
  always_comb begin
    case (vector_mode_i)
      alu_op_pkg::VEC_MODE16: lane_cut = 4'b0101;
      alu_op_pkg::VEC_MODE8:  lane_cut = 4'b1111;
      default:                lane_cut = 4'b0001;
    endcase
  end

  // Spacer bit below each byte passes, blocks or forces the carry
  always_comb begin
    for (int k = 0; k < simd_pkg::BYTE_LANES; k++) begin
      in_a[9*k]        = lane_cut[k] ? sub_i : 1'b1;
      in_b[9*k]        = lane_cut[k] & sub_i;
      in_a[9*k+1 +: 8] = operand_a_i.bytes[k];
      in_b[9*k+1 +: 8] = op_b.bytes[k];
    end
  end

  assign sum_ext = in_a + in_b;

  always_comb begin
    for (int k = 0; k < simd_pkg::BYTE_LANES; k++) begin
      sum_o[8*k +: 8] = sum_ext[9*k+1 +: 8];
    end
  end

endmodule

`default_nettype wire

// File: source/simd_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module simd_shifter (
  input  simd_pkg::simd_word_u  operand_a_i,
  input  simd_pkg::simd_word_u  operand_b_i,
  input  logic                  shift_left_i,
  input  logic                  shift_arith_i,
  input  alu_op_pkg::vec_mode_e vector_mode_i,
  output logic [31:0]           shift_o
);

  simd_pkg::simd_word_u op_a;
  simd_pkg::simd_word_u amt;
  simd_pkg::simd_word_u res_r;
  logic                 arith;
  logic signed [32:0]   word_sh;
  logic signed [16:0]   half_sh [simd_pkg::HALF_LANES];
  logic signed [8:0]    byte_sh [simd_pkg::BYTE_LANES];

  assign arith = shift_arith_i & ~shift_left_i;

  // Left shifts run through the right shifter on the mirrored word
  always_comb begin
    for (int i = 0; i < 32; i++) begin
      op_a.word[i] = shift_left_i ? operand_a_i.word[31-i] : operand_a_i.word[i];
    end
  end

  // Mirroring also reverses the lane order
  always_comb begin
    amt = operand_b_i;
    if (shift_left_i) begin
      case (vector_mode_i)
        alu_op_pkg::VEC_MODE16: begin
          amt.halves[0] = operand_b_i.halves[1];
          amt.halves[1] = operand_b_i.halves[0];
        end
        alu_op_pkg::VEC_MODE8: begin
          for (int k = 0; k < simd_pkg::BYTE_LANES; k++) begin
            amt.bytes[k] = operand_b_i.bytes[simd_pkg::BYTE_LANES-1-k];
          end
        end
        default: ;
      endcase
    end
  end

  assign word_sh = $signed({arith & op_a.word[31], op_a.word}) >>> amt.word[4:0];

  for (genvar h = 0; h < simd_pkg::HALF_LANES; h++) begin : gen_half
    assign half_sh[h] = $signed({arith & op_a.halves[h][15], op_a.halves[h]})
                        >>> amt.halves[h][3:0];
  end

  for (genvar b = 0; b < simd_pkg::BYTE_LANES; b++) begin : gen_byte
    assign byte_sh[b] = $signed({arith & op_a.bytes[b][7], op_a.bytes[b]})
                        >>> amt.bytes[b][2:0];
  end

  always_comb begin
    res_r.word = word_sh[31:0];
    case (vector_mode_i)
      alu_op_pkg::VEC_MODE16: begin
        for (int h = 0; h < simd_pkg::HALF_LANES; h++) begin
          res_r.halves[h] = half_sh[h][15:0];
        end
      end
      alu_op_pkg::VEC_MODE8: begin
        for (int b = 0; b < simd_pkg::BYTE_LANES; b++) begin
          res_r.bytes[b] = byte_sh[b][7:0];
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    for (int i = 0; i < 32; i++) begin
      shift_o[i] = shift_left_i ? res_r.word[31-i] : res_r.word[i];
    end
  end

endmodule

`default_nettype wire

// File: source/simd_compare_minmax.sv
`timescale 1ns/10ps
`default_nettype none

module simd_compare_minmax (
  input  simd_pkg::simd_word_u  operand_a_i,
  input  simd_pkg::simd_word_u  operand_b_i,
  input  logic                  cmp_signed_i,
  input  logic                  do_min_i,
  input  alu_op_pkg::vec_mode_e vector_mode_i,
  output logic [3:0]            is_equal_o,
  output logic [3:0]            is_greater_o,
  output logic [31:0]           minmax_o
);

  logic [3:0] lane_signed;
  logic [3:0] eq_b;
  logic [3:0] gt_b;
  logic       hi_gt;
  logic       lo_gt;
  logic [3:0] sel_a;

  // Only the top byte of each lane carries the sign
  always_comb begin
    case (vector_mode_i)
      alu_op_pkg::VEC_MODE16: lane_signed = {4{cmp_signed_i}} & 4'b1010;
      alu_op_pkg::VEC_MODE8:  lane_signed = {4{cmp_signed_i}};
      default:                lane_signed = {4{cmp_signed_i}} & 4'b1000;
    endcase
  end

  for (genvar b = 0; b < simd_pkg::BYTE_LANES; b++) begin : gen_byte_cmp
    assign eq_b[b] = operand_a_i.bytes[b] == operand_b_i.bytes[b];
    assign gt_b[b] = $signed({lane_signed[b] & operand_a_i.bytes[b][7], operand_a_i.bytes[b]})
                     > $signed({lane_signed[b] & operand_b_i.bytes[b][7], operand_b_i.bytes[b]});
  end

  assign hi_gt = gt_b[3] | (eq_b[3] & gt_b[2]);
  assign lo_gt = gt_b[1] | (eq_b[1] & gt_b[0]);

  always_comb begin
    case (vector_mode_i)
      alu_op_pkg::VEC_MODE16: begin
        is_equal_o[1:0]   = {2{&eq_b[1:0]}};
        is_equal_o[3:2]   = {2{&eq_b[3:2]}};
        is_greater_o[1:0] = {2{lo_gt}};
        is_greater_o[3:2] = {2{hi_gt}};
      end
      alu_op_pkg::VEC_MODE8: begin
        is_equal_o   = eq_b;
        is_greater_o = gt_b;
      end
      default: begin
        is_equal_o   = {4{&eq_b}};
        is_greater_o = {4{hi_gt | (&eq_b[3:2] & lo_gt)}};
      end
    endcase
  end

  // Byte from A when it wins the max, or loses it for min
  assign sel_a = is_greater_o ^ {4{do_min_i}};

  always_comb begin
    for (int b = 0; b < simd_pkg::BYTE_LANES; b++) begin
      minmax_o[8*b +: 8] = sel_a[b] ? operand_a_i.bytes[b] : operand_b_i.bytes[b];
    end
  end

endmodule

`default_nettype wire

// File: source/serial_divider.sv
`timescale 1ns/10ps
`default_nettype none

module serial_divider #(
  parameter int unsigned WIDTH = 32
) (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             start_i,
  input  logic             div_signed_i,
  input  logic             rem_i,
  input  logic             ex_ready_i,
  input  logic [WIDTH-1:0] dividend_i,
  input  logic [WIDTH-1:0] divisor_i,
  output logic [WIDTH-1:0] div_result_o,
  output logic             ready_o
);

  localparam int unsigned      CNT_W     = $clog2(WIDTH + 1);
  localparam logic [1:0]       ST_IDLE   = 2'd0;
  localparam logic [1:0]       ST_BUSY   = 2'd1;
  localparam logic [1:0]       ST_DONE   = 2'd2;
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(WIDTH);

  logic [1:0]       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [WIDTH-1:0] quot_q;
  logic [WIDTH-1:0] rem_q;
  logic [WIDTH-1:0] dvsr_q;
  logic [WIDTH-1:0] result_q;
  logic             rem_sel_q;
  logic             quot_neg_q;
  logic             rem_neg_q;
  logic             a_neg;
  logic             b_neg;
  logic [WIDTH-1:0] a_mag;
  logic [WIDTH-1:0] b_mag;
  logic [WIDTH:0]   rem_shift;
  logic [WIDTH+1:0] trial;
  logic [WIDTH-1:0] quot_fix;
  logic [WIDTH-1:0] rem_fix;

  assign a_neg = div_signed_i & dividend_i[WIDTH-1];
  assign b_neg = div_signed_i & divisor_i[WIDTH-1];
  assign a_mag = a_neg ? -dividend_i : dividend_i;
  assign b_mag = b_neg ? -divisor_i : divisor_i;

  // Next dividend bit enters the partial remainder each step
  assign rem_shift = {rem_q, quot_q[WIDTH-1]};
  assign trial     = {1'b0, rem_shift} - {2'b00, dvsr_q};

  assign quot_fix = quot_neg_q ? -quot_q : quot_q;
  assign rem_fix  = rem_neg_q ? -rem_q : rem_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_BUSY;
            cnt_q   <= '0;
          end
        end
        ST_BUSY: begin
          if (cnt_q == LAST_STEP) begin
            state_q <= ST_DONE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        ST_DONE: begin
          if (ex_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && start_i) begin
      quot_q     <= a_mag;
      rem_q      <= '0;
      dvsr_q     <= b_mag;
      rem_sel_q  <= rem_i;
      rem_neg_q  <= a_neg;
      // Zero divisor keeps the all-ones quotient unsigned
      quot_neg_q <= (a_neg ^ b_neg) & (|divisor_i);
    end else if (state_q == ST_BUSY) begin
      if (cnt_q == LAST_STEP) begin
        result_q <= rem_sel_q ? rem_fix : quot_fix;
      end else begin
        quot_q <= {quot_q[WIDTH-2:0], ~trial[WIDTH+1]};
        rem_q  <= trial[WIDTH+1] ? rem_shift[WIDTH-1:0] : trial[WIDTH-1:0];
      end
    end
  end

  assign div_result_o = result_q;
  assign ready_o      = state_q != ST_BUSY;

endmodule

`default_nettype wire

// File: source/rv32_simd_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv32_simd_alu (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  logic                    enable_i,
  input  logic                    ex_ready_i,
  input  alu_op_pkg::alu_opcode_e operator_i,
  input  alu_op_pkg::vec_mode_e   vector_mode_i,
  input  logic [31:0]             operand_a_i,
  input  logic [31:0]             operand_b_i,
  output logic [31:0]             result_o,
  output logic                    comparison_result_o,
  output logic                    ready_o
);

  simd_pkg::simd_word_u  op_a;
  simd_pkg::simd_word_u  op_b;
  alu_op_pkg::vec_mode_e cmp_mode;
  logic                  sub;
  logic                  shift_left;
  logic                  shift_arith;
  logic                  cmp_signed;
  logic                  do_min;
  logic                  is_slt;
  logic                  is_div;
  logic                  div_signed;
  logic                  div_rem;
  logic                  div_start;
  logic                  div_ready;
  logic [31:0]           sum;
  logic [31:0]           shift_res;
  logic [31:0]           minmax;
  logic [31:0]           div_result;
  logic [3:0]            is_equal;
  logic [3:0]            is_greater;
  logic [3:0]            cmp_result;

  assign op_a.word = operand_a_i;
  assign op_b.word = operand_b_i;

  assign sub         = operator_i == alu_op_pkg::ALU_SUB;
  assign shift_left  = operator_i == alu_op_pkg::ALU_SLL;
  assign shift_arith = operator_i == alu_op_pkg::ALU_SRA;
  assign do_min      = (operator_i == alu_op_pkg::ALU_MIN) || (operator_i == alu_op_pkg::ALU_MINU);
  assign is_slt      = (operator_i == alu_op_pkg::ALU_SLTS) || (operator_i == alu_op_pkg::ALU_SLTU);
  assign div_signed  = (operator_i == alu_op_pkg::ALU_DIV) || (operator_i == alu_op_pkg::ALU_REM);
  assign div_rem     = (operator_i == alu_op_pkg::ALU_REM) || (operator_i == alu_op_pkg::ALU_REMU);
  assign is_div      = div_signed || div_rem || (operator_i == alu_op_pkg::ALU_DIVU);
  assign div_start   = enable_i & is_div & div_ready;

  always_comb begin
    case (operator_i)
      alu_op_pkg::ALU_GTS, alu_op_pkg::ALU_GES, alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LES,
      alu_op_pkg::ALU_SLTS, alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MAX: cmp_signed = 1'b1;
      default: cmp_signed = 1'b0;
    endcase
  end

  // Set-less-than always compares whole words
  assign cmp_mode = is_slt ? alu_op_pkg::VEC_MODE32 : vector_mode_i;

  simd_adder u_adder (
    .operand_a_i  (op_a),
    .operand_b_i  (op_b),
    .sub_i        (sub),
    .vector_mode_i(vector_mode_i),
    .sum_o        (sum)
  );

  simd_shifter u_shifter (
    .operand_a_i  (op_a),
    .operand_b_i  (op_b),
    .shift_left_i (shift_left),
    .shift_arith_i(shift_arith),
    .vector_mode_i(vector_mode_i),
    .shift_o      (shift_res)
  );

  simd_compare_minmax u_compare (
    .operand_a_i  (op_a),
    .operand_b_i  (op_b),
    .cmp_signed_i (cmp_signed),
    .do_min_i     (do_min),
    .vector_mode_i(cmp_mode),
    .is_equal_o   (is_equal),
    .is_greater_o (is_greater),
    .minmax_o     (minmax)
  );

  serial_divider #(
    .WIDTH(simd_pkg::WORD_W)
  ) u_divider (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .start_i     (div_start),
    .div_signed_i(div_signed),
    .rem_i       (div_rem),
    .ex_ready_i  (ex_ready_i),
    .dividend_i  (operand_a_i),
    .divisor_i   (operand_b_i),
    .div_result_o(div_result),
    .ready_o     (div_ready)
  );

  always_comb begin
    case (operator_i)
      alu_op_pkg::ALU_NE:                       cmp_result = ~is_equal;
      alu_op_pkg::ALU_GTS, alu_op_pkg::ALU_GTU: cmp_result = is_greater;
      alu_op_pkg::ALU_GES, alu_op_pkg::ALU_GEU: cmp_result = is_greater | is_equal;
      alu_op_pkg::ALU_LES, alu_op_pkg::ALU_LEU: cmp_result = ~is_greater;
      alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LTU,
      alu_op_pkg::ALU_SLTS, alu_op_pkg::ALU_SLTU: cmp_result = ~(is_greater | is_equal);
      default:                                  cmp_result = is_equal;
    endcase
  end

  assign comparison_result_o = cmp_result[3];

  always_comb begin
    case (operator_i)
      alu_op_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      alu_op_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      alu_op_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      alu_op_pkg::ALU_ADD, alu_op_pkg::ALU_SUB: result_o = sum;
      alu_op_pkg::ALU_SLL, alu_op_pkg::ALU_SRL, alu_op_pkg::ALU_SRA: result_o = shift_res;
      alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MINU,
      alu_op_pkg::ALU_MAX, alu_op_pkg::ALU_MAXU: result_o = minmax;
      alu_op_pkg::ALU_EQ, alu_op_pkg::ALU_NE,
      alu_op_pkg::ALU_GTS, alu_op_pkg::ALU_GTU, alu_op_pkg::ALU_GES, alu_op_pkg::ALU_GEU,
      alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LTU, alu_op_pkg::ALU_LES, alu_op_pkg::ALU_LEU: begin
        result_o = {{8{cmp_result[3]}}, {8{cmp_result[2]}}, {8{cmp_result[1]}}, {8{cmp_result[0]}}};
      end
      alu_op_pkg::ALU_SLTS, alu_op_pkg::ALU_SLTU: result_o = {31'b0, comparison_result_o};
      alu_op_pkg::ALU_DIV, alu_op_pkg::ALU_DIVU,
      alu_op_pkg::ALU_REM, alu_op_pkg::ALU_REMU: result_o = div_result;
      default: result_o = '0;
    endcase
  end

  assign ready_o = div_ready;

endmodule

`default_nettype wire

// File: verification/rv32_simd_alu_assert.sv
`timescale 1ns/10ps
`default_nettype none

module rv32_simd_alu_assert #(
  parameter int unsigned WIDTH = 32
) (
  input logic             clk,
  input logic             arst_n_i,
  input logic             start_i,
  input logic             ex_ready_i,
  input logic             idle_i,
  input logic             done_i,
  input logic             ready_i,
  input logic [WIDTH-1:0] result_i
);

  int unsigned low_cnt;

  // Length of the current low phase of ready
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      low_cnt <= 0;
    end else if (!ready_i) begin
      low_cnt <= low_cnt + 1;
    end else begin
      low_cnt <= 0;
    end
  end

  ready_after_reset: assert property (@(posedge clk) !arst_n_i |=> ready_i)
    else $error("divider not ready after reset");

  start_drops_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
    start_i && idle_i |=> !ready_i)
    else $error("divider did not leave ready on a start");

  low_phase_length: assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(ready_i) |-> low_cnt == WIDTH + 1)
    else $error("divider busy phase has the wrong length");

  low_phase_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
    !ready_i |-> low_cnt <= WIDTH)
    else $error("divider busy for too long");

  // Result must not move while the consumer is stalled
  result_held: assert property (@(posedge clk) disable iff (!arst_n_i)
    done_i && !ex_ready_i |=> $stable(result_i))
    else $error("divider result changed under back-pressure");

endmodule

`default_nettype wire

// File: verification/rv32_simd_alu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv32_simd_alu_tb;

  localparam int HALF_PERIOD = 10;
  localparam int DIV_CYCLES  = simd_pkg::WORD_W + 1;
  localparam int WAIT_LIMIT  = 100;

  logic                    clk;
  logic                    arst_n;
  logic                    enable;
  logic                    ex_ready;
  alu_op_pkg::alu_opcode_e operator;
  alu_op_pkg::vec_mode_e   vec_mode;
  logic [31:0]             op_a;
  logic [31:0]             op_b;
  logic [31:0]             result;
  logic                    cmp_result;
  logic                    ready;

  logic [31:0] lfsr_q;
  int          checks;
  int          errors;
  int          timeouts;

  alu_op_pkg::vec_mode_e test_modes [3] = '{alu_op_pkg::VEC_MODE32,
                                            alu_op_pkg::VEC_MODE16, alu_op_pkg::VEC_MODE8};
  alu_op_pkg::alu_opcode_e cmp_ops [12] = '{alu_op_pkg::ALU_EQ, alu_op_pkg::ALU_NE,
    alu_op_pkg::ALU_GTS, alu_op_pkg::ALU_GTU, alu_op_pkg::ALU_GES, alu_op_pkg::ALU_GEU,
    alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LTU, alu_op_pkg::ALU_LES, alu_op_pkg::ALU_LEU,
    alu_op_pkg::ALU_SLTS, alu_op_pkg::ALU_SLTU};
  alu_op_pkg::alu_opcode_e mm_ops [4] = '{alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MAX,
    alu_op_pkg::ALU_MINU, alu_op_pkg::ALU_MAXU};
  alu_op_pkg::alu_opcode_e div_ops [4] = '{alu_op_pkg::ALU_DIV, alu_op_pkg::ALU_DIVU,
    alu_op_pkg::ALU_REM, alu_op_pkg::ALU_REMU};

  rv32_simd_alu dut (
    .clk                (clk),
    .arst_n_i           (arst_n),
    .enable_i           (enable),
    .ex_ready_i         (ex_ready),
    .operator_i         (operator),
    .vector_mode_i      (vec_mode),
    .operand_a_i        (op_a),
    .operand_b_i        (op_b),
    .result_o           (result),
    .comparison_result_o(cmp_result),
    .ready_o            (ready)
  );

  bind serial_divider rv32_simd_alu_assert #(
    .WIDTH(WIDTH)
  ) u_div_assert (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .start_i   (start_i),
    .ex_ready_i(ex_ready_i),
    .idle_i    (state_q == ST_IDLE),
    .done_i    (state_q == ST_DONE),
    .ready_i   (ready_o),
    .result_i  (div_result_o)
  );

  initial clk = 1'b0;
  always #HALF_PERIOD clk = ~clk;

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic next_lfsr_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lsb ? 32'h8020_0003 : 32'h0);
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_lfsr_bit()};
    end
    return v;
  endfunction

  function automatic int lane_width(alu_op_pkg::vec_mode_e mode);
    case (mode)
      alu_op_pkg::VEC_MODE16: return 16;
      alu_op_pkg::VEC_MODE8:  return 8;
      default:                return 32;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(int w);
    return (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 1);
  endfunction

  function automatic logic signed_order(alu_op_pkg::alu_opcode_e op);
    case (op)
      alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LES, alu_op_pkg::ALU_GTS, alu_op_pkg::ALU_GES,
      alu_op_pkg::ALU_SLTS, alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MAX: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic compare_op(alu_op_pkg::alu_opcode_e op);
    foreach (cmp_ops[k]) begin
      if (cmp_ops[k] == op) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Lane by lane model; the top bit is the flag of the top lane
  function automatic logic [32:0] expected_comb(alu_op_pkg::alu_opcode_e op,
                                                alu_op_pkg::vec_mode_e mode,
                                                logic [31:0] a, logic [31:0] b);
    int          w;
    logic [31:0] m;
    logic [31:0] la;
    logic [31:0] lb;
    logic [31:0] sa;
    logic [31:0] sb;
    logic [31:0] sx;
    logic [31:0] amt;
    logic [31:0] r;
    logic [31:0] res;
    logic        gt;
    logic        eq;
    logic        c;
    w   = (op == alu_op_pkg::ALU_SLTS || op == alu_op_pkg::ALU_SLTU) ? 32 : lane_width(mode);
    m   = lane_mask(w);
    res = '0;
    c   = 1'b0;
    for (int k = 0; k < 32 / w; k++) begin
      la  = (a >> (k * w)) & m;
      lb  = (b >> (k * w)) & m;
      amt = lb & (w - 1);
      // Flipping the sign bit turns signed order into unsigned order
      sa  = signed_order(op) ? la ^ (32'd1 << (w - 1)) : la;
      sb  = signed_order(op) ? lb ^ (32'd1 << (w - 1)) : lb;
      gt  = sa > sb;
      eq  = la == lb;
      sx  = la[w-1] ? (la | ~m) : la;
      case (op)
        alu_op_pkg::ALU_EQ:                       c = eq;
        alu_op_pkg::ALU_NE:                       c = !eq;
        alu_op_pkg::ALU_GTS, alu_op_pkg::ALU_GTU: c = gt;
        alu_op_pkg::ALU_GES, alu_op_pkg::ALU_GEU: c = gt || eq;
        alu_op_pkg::ALU_LES, alu_op_pkg::ALU_LEU: c = !gt;
        default:                                  c = !gt && !eq;
      endcase
      case (op)
        alu_op_pkg::ALU_AND:  r = la & lb;
        alu_op_pkg::ALU_OR:   r = la | lb;
        alu_op_pkg::ALU_XOR:  r = la ^ lb;
        alu_op_pkg::ALU_ADD:  r = la + lb;
        alu_op_pkg::ALU_SUB:  r = la - lb;
        alu_op_pkg::ALU_SLL:  r = la << amt;
        alu_op_pkg::ALU_SRL:  r = la >> amt;
        alu_op_pkg::ALU_SRA:  r = $signed(sx) >>> amt;
        alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MINU: r = gt ? lb : la;
        alu_op_pkg::ALU_MAX, alu_op_pkg::ALU_MAXU: r = gt ? la : lb;
        alu_op_pkg::ALU_SLTS, alu_op_pkg::ALU_SLTU: r = {31'b0, c};
        default:              r = {32{c}};
      endcase
      res = res | ((r & m) << (k * w));
    end
    return {c, res};
  endfunction

  function automatic logic [31:0] expected_div(alu_op_pkg::alu_opcode_e op,
                                               logic [31:0] a, logic [31:0] b);
    logic        sgn;
    logic        rem;
    logic        a_neg;
    logic        b_neg;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [31:0] q;
    logic [31:0] r;
    sgn = (op == alu_op_pkg::ALU_DIV) || (op == alu_op_pkg::ALU_REM);
    rem = (op == alu_op_pkg::ALU_REM) || (op == alu_op_pkg::ALU_REMU);
    if (b == 0) begin
      return rem ? a : 32'hffff_ffff;
    end
    if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return rem ? 32'h0 : a;
    end
    a_neg = sgn && a[31];
    b_neg = sgn && b[31];
    a_mag = a_neg ? -a : a;
    b_mag = b_neg ? -b : b;
    q     = a_mag / b_mag;
    r     = a_mag % b_mag;
    if (rem) begin
      return a_neg ? -r : r;
    end
    return (a_neg ^ b_neg) ? -q : q;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic apply_comb(alu_op_pkg::alu_opcode_e op, alu_op_pkg::vec_mode_e mode,
                            logic [31:0] a, logic [31:0] b);
    logic [32:0] exp;
    exp = expected_comb(op, mode, a, b);
    @(negedge clk);
    operator = op;
    vec_mode = mode;
    op_a     = a;
    op_b     = b;
    #(HALF_PERIOD / 2);
    check_value($sformatf("result_o %s %s", op.name(), mode.name()), result, exp[31:0]);
    if (compare_op(op)) begin
      check_value($sformatf("comparison_result_o %s", op.name()), {31'b0, cmp_result},
                  {31'b0, exp[32]});
    end
  endtask

  // Drops enable after the start edge and counts the busy cycles
  task automatic wait_div_ready(output int lows);
    lows = 0;
    @(negedge clk);
    enable = 1'b0;
    while (!ready && lows < WAIT_LIMIT) begin
      lows++;
      @(negedge clk);
    end
    if (!ready) begin
      timeouts++;
      $display("Timeout: divider did not become ready within %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic apply_div(alu_op_pkg::alu_opcode_e op, logic [31:0] a, logic [31:0] b);
    int lows;
    @(negedge clk);
    operator = op;
    vec_mode = alu_op_pkg::VEC_MODE32;
    op_a     = a;
    op_b     = b;
    enable   = 1'b1;
    wait_div_ready(lows);
    check_value("ready_o low cycles", lows, DIV_CYCLES);
    check_value($sformatf("result_o %s", op.name()), result, expected_div(op, a, b));
  endtask

  task automatic logic_and_add_sub();
    logic [31:0] a;
    logic [31:0] b;
    foreach (test_modes[m]) begin
      for (int i = 0; i < 8; i++) begin
        a = rand_bits(32);
        b = rand_bits(32);
        apply_comb(alu_op_pkg::ALU_AND, test_modes[m], a, b);
        apply_comb(alu_op_pkg::ALU_OR, test_modes[m], a, b);
        apply_comb(alu_op_pkg::ALU_XOR, test_modes[m], a, b);
        apply_comb(alu_op_pkg::ALU_ADD, test_modes[m], a, b);
        apply_comb(alu_op_pkg::ALU_SUB, test_modes[m], a, b);
      end
      // Carry out of every lane and borrow into every lane
      apply_comb(alu_op_pkg::ALU_ADD, test_modes[m], 32'hffff_ffff, 32'h0101_0101);
      apply_comb(alu_op_pkg::ALU_ADD, test_modes[m], 32'h80ff_7fff, 32'h8001_0001);
      apply_comb(alu_op_pkg::ALU_SUB, test_modes[m], 32'h0000_0000, 32'h0101_0101);
      apply_comb(alu_op_pkg::ALU_SUB, test_modes[m], 32'h0100_0001, 32'h0201_0002);
    end
  endtask

  task automatic shift_lanes();
    logic [31:0] a;
    logic [31:0] b;
    foreach (test_modes[m]) begin
      for (int i = 0; i < 8; i++) begin
        a = rand_bits(32);
        b = rand_bits(32);
        apply_comb(alu_op_pkg::ALU_SLL, test_modes[m], a, b);
        apply_comb(alu_op_pkg::ALU_SRL, test_modes[m], a, b);
        apply_comb(alu_op_pkg::ALU_SRA, test_modes[m], a, b);
        // Every lane negative
        apply_comb(alu_op_pkg::ALU_SRA, test_modes[m], a | 32'h8080_8080, b);
      end
    end
  endtask

  task automatic compare_lanes();
    logic [31:0] a;
    logic [31:0] b;
    foreach (test_modes[m]) begin
      for (int i = 0; i < 8; i++) begin
        a = rand_bits(32);
        case (i)
          0:       b = a;
          1:       b = a ^ 32'h0001_0001;
          2:       b = a ^ 32'h8080_8080;
          default: b = rand_bits(32);
        endcase
        foreach (cmp_ops[k]) begin
          apply_comb(cmp_ops[k], test_modes[m], a, b);
        end
      end
    end
  endtask

  task automatic min_max_lanes();
    logic [31:0] a;
    logic [31:0] b;
    foreach (test_modes[m]) begin
      for (int i = 0; i < 8; i++) begin
        a = (i == 0) ? 32'h8080_8080 : (i == 1) ? 32'h807f_0080 : rand_bits(32);
        b = (i == 0) ? 32'h7f7f_7f7f : (i == 1) ? 32'h7f80_ff7f : rand_bits(32);
        foreach (mm_ops[k]) begin
          apply_comb(mm_ops[k], test_modes[m], a, b);
        end
      end
    end
  endtask

  task automatic divide_cases();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 10; i++) begin
      a = rand_bits(32);
      if (i == 0) begin
        b = 32'h0;
      end else if (i == 1) begin
        a = 32'h8000_0000;
        b = 32'hffff_ffff;
      end else if (i < 5) begin
        b = rand_bits(32);
      end else begin
        b = rand_bits(10);
        if (i > 7) begin
          b = -b;
        end
      end
      foreach (div_ops[k]) begin
        apply_div(div_ops[k], a, b);
      end
    end
  endtask

  task automatic divider_back_pressure();
    logic [31:0] a1;
    logic [31:0] b1;
    logic [31:0] a2;
    logic [31:0] b2;
    logic [31:0] held;
    int          lows;
    int          n;
    a1   = rand_bits(32);
    b1   = rand_bits(9);
    a2   = rand_bits(32);
    b2   = rand_bits(12);
    held = expected_div(alu_op_pkg::ALU_DIVU, a1, b1);
    @(negedge clk);
    ex_ready = 1'b0;
    apply_div(alu_op_pkg::ALU_DIVU, a1, b1);
    // Second request while the first result is still pending
    op_a   = a2;
    op_b   = b2;
    enable = 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_value("result_o under back-pressure", result, held);
      check_value("ready_o under back-pressure", {31'b0, ready}, 32'h1);
    end
    ex_ready = 1'b1;
    n = 0;
    @(negedge clk);
    while (ready && n < 4) begin
      n++;
      @(negedge clk);
    end
    if (ready) begin
      timeouts++;
      $display("Timeout: second division did not start after ex_ready_i rose");
    end
    wait_div_ready(lows);
    check_value("ready_o low cycles", lows + 1, DIV_CYCLES);
    check_value("result_o second DIVU", result, expected_div(alu_op_pkg::ALU_DIVU, a2, b2));
  endtask

  initial begin
    lfsr_q   = 32'h2d4c6a1b;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    arst_n   = 1'b0;
    enable   = 1'b0;
    ex_ready = 1'b1;
    operator = alu_op_pkg::ALU_ADD;
    vec_mode = alu_op_pkg::VEC_MODE32;
    op_a     = '0;
    op_b     = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_value("ready_o after reset", {31'b0, ready}, 32'h1);
    logic_and_add_sub();
    shift_lanes();
    compare_lanes();
    min_max_lanes();
    divide_cases();
    divider_back_pressure();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: simd_alu.f
source/alu_op_pkg.sv
source/simd_pkg.sv
source/simd_adder.sv
source/simd_shifter.sv
source/simd_compare_minmax.sv
source/serial_divider.sv
source/rv32_simd_alu.sv
verification/rv32_simd_alu_assert.sv
verification/rv32_simd_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module rv32_simd_alu_tb \
  --Mdir obj_dir \
  -f simd_alu.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vrv32_simd_alu_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
